// ==== ex_alu.sv ====
// Single-cycle RV32I execute unit
// Arithmetic, logic, shifts, LUI, branch decision and jump targets
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
    input  wire ex_pkg::alu_op_e                op,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  a,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  b,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  rs1_data,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  rs2_data,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  pc,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  imm,
    output logic      [ex_pkg::DATA_WIDTH-1:0]  result,
    output logic                                taken,
    output logic      [ex_pkg::DATA_WIDTH-1:0]  target
);
    localparam int W = ex_pkg::DATA_WIDTH;

    logic [W-1:0] br_target;
    logic [W-1:0] jalr_sum;
    logic [W-1:0] link;

    assign br_target = pc + imm;
    assign jalr_sum  = rs1_data + imm;
    assign link      = pc + W'(4);

    always_comb begin
        result = '0;
        taken  = 1'b0;
        target = '0;
        case (op)
            ex_pkg::OP_ADD:  result = a + b;
            ex_pkg::OP_SUB:  result = a - b;
            ex_pkg::OP_SLL:  result = a << b[4:0];
            ex_pkg::OP_SLT:  result = W'($signed(a) < $signed(b));
            ex_pkg::OP_SLTU: result = W'(a < b);
            ex_pkg::OP_XOR:  result = a ^ b;
            ex_pkg::OP_SRL:  result = a >> b[4:0];
            ex_pkg::OP_SRA:  result = $signed(a) >>> b[4:0];
            ex_pkg::OP_OR:   result = a | b;
            ex_pkg::OP_AND:  result = a & b;
            ex_pkg::OP_LUI:  result = b;  // Immediate already shifted by decode
            ex_pkg::OP_BEQ:  taken = (rs1_data == rs2_data);
            ex_pkg::OP_BNE:  taken = (rs1_data != rs2_data);
            ex_pkg::OP_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            ex_pkg::OP_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            ex_pkg::OP_BLTU: taken = (rs1_data < rs2_data);
            ex_pkg::OP_BGEU: taken = (rs1_data >= rs2_data);
            ex_pkg::OP_JAL: begin
                result = link;
                taken  = 1'b1;
            end
            ex_pkg::OP_JALR: begin
                result = link;
                taken  = 1'b1;
                target = {jalr_sum[W-1:1], 1'b0};
            end
            default: result = '0;  // M opcodes are handled elsewhere
        endcase
        // Branches and JAL share the PC-relative target
        if (op inside {ex_pkg::OP_BEQ, ex_pkg::OP_BNE, ex_pkg::OP_BLT, ex_pkg::OP_BGE,
                       ex_pkg::OP_BLTU, ex_pkg::OP_BGEU, ex_pkg::OP_JAL}) begin
            target = br_target;
        end
    end

endmodule

`default_nettype wire

// ==== ex_issue.sv ====
// Round-robin issue of incoming instructions to the execute lanes
// Only the lane at the pointer sees in_valid, and its ready goes back out
`timescale 1ns/10ps
`default_nettype none

module ex_issue #(
    parameter int LANES = 2
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              in_valid,
    output logic                   in_ready,
    output logic [LANES-1:0]       lane_in_valid,
    input  wire logic [LANES-1:0]  lane_in_ready
);
    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [PTR_W-1:0] ptr;
    logic             xfer;

    assign in_ready = lane_in_ready[ptr];
    assign xfer     = in_valid && in_ready;

    always_comb begin
        lane_in_valid      = '0;
        lane_in_valid[ptr] = in_valid;
    end

    // Pointer order must match the retire side so results stay in issue order
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (xfer) begin
            if (ptr == PTR_W'(LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== ex_lane.sv ====
// One execute lane holding a single instruction
// Selects operands, runs the ALU or the M unit and keeps the result until retire
`timescale 1ns/10ps
`default_nettype none

module ex_lane (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           in_valid,
    output logic                                in_ready,
    input  wire ex_pkg::alu_op_e                op,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  rs1_data,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  rs2_data,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  pc,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  imm,
    input  wire logic                           sel_pc,
    input  wire logic                           sel_imm,
    output logic                                out_valid,
    input  wire logic                           out_ready,
    output logic      [ex_pkg::DATA_WIDTH-1:0]  result,
    output logic      [ex_pkg::DATA_WIDTH-1:0]  target,
    output logic                                taken
);
    localparam int W = ex_pkg::DATA_WIDTH;

    logic [W-1:0] opa;
    logic [W-1:0] opb;
    logic [W-1:0] alu_result;
    logic [W-1:0] alu_target;
    logic         alu_taken;
    logic [W-1:0] md_result;
    logic         md_done;
    logic         accept;
    logic         xfer;
    logic         full;
    logic         m_ready;  // M unit has delivered for the held instruction
    logic         is_m;
    logic [W-1:0] res_q;
    logic [W-1:0] target_q;
    logic         taken_q;

    assign opa = sel_pc ? pc : rs1_data;
    assign opb = sel_imm ? imm : rs2_data;

    assign in_ready  = !full;
    assign accept    = in_valid && !full;
    assign out_valid = full && (!is_m || m_ready || md_done);
    assign xfer      = out_valid && out_ready;
    assign result    = is_m ? md_result : res_q;
    assign target    = target_q;
    assign taken     = taken_q;

    ex_alu u_alu (
        .op       (op),
        .a        (opa),
        .b        (opb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .imm      (imm),
        .result   (alu_result),
        .taken    (alu_taken),
        .target   (alu_target)
    );

    ex_muldiv u_muldiv (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (accept && ex_pkg::is_muldiv(op)),
        .op     (op),
        .a      (opa),
        .b      (opb),
        .done   (md_done),
        .result (md_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full    <= 1'b0;
            m_ready <= 1'b0;
        end else begin
            if (accept) full <= 1'b1;
            else if (xfer) full <= 1'b0;
            if (accept || xfer) m_ready <= 1'b0;
            else if (md_done) m_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            is_m     <= ex_pkg::is_muldiv(op);
            res_q    <= alu_result;
            target_q <= alu_target;
            taken_q  <= alu_taken;
        end
    end

endmodule

`default_nettype wire

// ==== ex_muldiv.sv ====
// RV32M unit with a one-cycle multiply and a restoring bit-serial divide
// Result is held until the next start, done pulses for one cycle
`timescale 1ns/10ps
`default_nettype none

module ex_muldiv (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           start,
    input  wire ex_pkg::alu_op_e                op,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  a,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  b,
    output logic                                done,
    output logic      [ex_pkg::DATA_WIDTH-1:0]  result
);
    localparam int W  = ex_pkg::DATA_WIDTH;
    localparam int CW = $clog2(W);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e state;

    logic                  a_signed;
    logic                  b_signed;
    logic                  is_div;
    logic [W:0]            a_ext;
    logic [W:0]            b_ext;
    logic signed [2*W+1:0] product;
    logic [W-1:0]          a_mag;
    logic [W-1:0]          b_mag;
    logic [CW-1:0]         cnt;
    logic [W-1:0]          quo;
    logic [W-1:0]          rem;
    logic [W-1:0]          dvs;
    logic                  neg_q;
    logic                  neg_r;
    logic                  want_rem;
    logic                  b_zero;
    logic [W:0]            rem_shift;
    logic [W:0]            rem_diff;

    always_comb begin
        a_signed = op inside {ex_pkg::OP_MULH, ex_pkg::OP_MULHSU, ex_pkg::OP_DIV, ex_pkg::OP_REM};
        b_signed = op inside {ex_pkg::OP_MULH, ex_pkg::OP_DIV, ex_pkg::OP_REM};
        is_div   = op inside {ex_pkg::OP_DIV, ex_pkg::OP_DIVU, ex_pkg::OP_REM, ex_pkg::OP_REMU};
        a_ext    = {a_signed & a[W-1], a};
        b_ext    = {b_signed & b[W-1], b};
        product  = $signed(a_ext) * $signed(b_ext);  // Exact 66-bit product
        a_mag    = (a_signed && a[W-1]) ? -a : a;
        b_mag    = (b_signed && b[W-1]) ? -b : b;
    end

    // One restoring step per cycle, quotient bits shift in from the right
    assign rem_shift = {rem, quo[W-1]};
    assign rem_diff  = rem_shift - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= DIV_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (start && is_div) begin
                        state <= DIV_RUN;
                    end else if (start) begin
                        done <= 1'b1;  // Multiply finishes at once
                    end
                end
                DIV_RUN: begin
                    if (cnt == CW'(W - 1)) state <= DIV_DONE;
                end
                default: begin
                    state <= DIV_IDLE;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            cnt      <= '0;
            quo      <= a_mag;
            rem      <= '0;
            dvs      <= b_mag;
            neg_q    <= a_signed & (a[W-1] ^ b[W-1]);
            neg_r    <= a_signed & a[W-1];
            want_rem <= op inside {ex_pkg::OP_REM, ex_pkg::OP_REMU};
            b_zero   <= (b == '0);
            if (!is_div) begin
                result <= (op == ex_pkg::OP_MUL) ? product[W-1:0] : product[2*W-1:W];
            end
        end else if (state == DIV_RUN) begin
            cnt <= cnt + 1'b1;
            if (!rem_diff[W]) begin
                rem <= rem_diff[W-1:0];
                quo <= {quo[W-2:0], 1'b1};
            end else begin
                rem <= rem_shift[W-1:0];
                quo <= {quo[W-2:0], 1'b0};
            end
        end else if (state == DIV_DONE) begin
            if (want_rem) begin
                result <= neg_r ? -rem : rem;
            end else begin
                result <= b_zero ? '1 : (neg_q ? -quo : quo);  // Divide by zero gives all ones
            end
        end
    end

endmodule

`default_nettype wire

// ==== ex_pkg.sv ====
// Execute stage package for the RV32IM core
// Holds the datapath width, the execute opcode set and the M-extension test
`default_nettype none

package ex_pkg;

    localparam int unsigned DATA_WIDTH = 32;

    typedef enum logic [4:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_SLL    = 5'd2,
        OP_SLT    = 5'd3,
        OP_SLTU   = 5'd4,
        OP_XOR    = 5'd5,
        OP_SRL    = 5'd6,
        OP_SRA    = 5'd7,
        OP_OR     = 5'd8,
        OP_AND    = 5'd9,
        OP_LUI    = 5'd10,
        OP_BEQ    = 5'd11,  // Branches compare rs1 with rs2
        OP_BNE    = 5'd12,
        OP_BLT    = 5'd13,
        OP_BGE    = 5'd14,
        OP_BLTU   = 5'd15,
        OP_BGEU   = 5'd16,
        OP_JAL    = 5'd17,
        OP_JALR   = 5'd18,
        OP_MUL    = 5'd19,  // M extension from here on
        OP_MULH   = 5'd20,
        OP_MULHSU = 5'd21,
        OP_MULHU  = 5'd22,
        OP_DIV    = 5'd23,
        OP_DIVU   = 5'd24,
        OP_REM    = 5'd25,
        OP_REMU   = 5'd26
    } alu_op_e;

    function automatic logic is_muldiv(alu_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                          OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

endpackage

`default_nettype wire

// ==== ex_retire.sv ====
// Round-robin retire of lane results onto the output handshake
// Follows the same lane order as issue, so results leave in program order
`timescale 1ns/10ps
`default_nettype none

module ex_retire #(
    parameter int LANES = 2
) (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n,
    input  wire logic [LANES-1:0]                           lane_out_valid,
    input  wire logic [LANES-1:0][ex_pkg::DATA_WIDTH-1:0]   lane_result,
    input  wire logic [LANES-1:0][ex_pkg::DATA_WIDTH-1:0]   lane_target,
    input  wire logic [LANES-1:0]                           lane_taken,
    output logic      [LANES-1:0]                           lane_out_ready,
    output logic                                            out_valid,
    input  wire logic                                       out_ready,
    output logic      [ex_pkg::DATA_WIDTH-1:0]              result,
    output logic      [ex_pkg::DATA_WIDTH-1:0]              target,
    output logic                                            taken
);
    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [PTR_W-1:0] ptr;

    assign out_valid = lane_out_valid[ptr];
    assign result    = lane_result[ptr];
    assign target    = lane_target[ptr];
    assign taken     = lane_taken[ptr];

    always_comb begin
        lane_out_ready      = '0;
        lane_out_ready[ptr] = out_ready;  // Other lanes hold their results
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (out_valid && out_ready) begin
            if (ptr == PTR_W'(LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== ex_top.sv ====
// Multi-lane execute stage of the RV32IM core
// Issue unit, a row of identical lanes and an in-order retire unit
`timescale 1ns/10ps
`default_nettype none

module ex_top #(
    parameter int LANES = 2
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           in_valid,
    output logic                                in_ready,
    input  wire ex_pkg::alu_op_e                op,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  rs1_data,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  rs2_data,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  pc,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  imm,
    input  wire logic                           sel_pc,
    input  wire logic                           sel_imm,
    output logic                                out_valid,
    input  wire logic                           out_ready,
    output logic      [ex_pkg::DATA_WIDTH-1:0]  result,
    output logic                                branch_taken,
    output logic      [ex_pkg::DATA_WIDTH-1:0]  branch_target
);
    logic [LANES-1:0]                         lane_in_valid;
    logic [LANES-1:0]                         lane_in_ready;
    logic [LANES-1:0]                         lane_out_valid;
    logic [LANES-1:0]                         lane_out_ready;
    logic [LANES-1:0]                         lane_taken;
    logic [LANES-1:0][ex_pkg::DATA_WIDTH-1:0] lane_result;
    logic [LANES-1:0][ex_pkg::DATA_WIDTH-1:0] lane_target;

    ex_issue #(.LANES(LANES)) u_issue (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .lane_in_valid (lane_in_valid),
        .lane_in_ready (lane_in_ready)
    );

    // Payload is broadcast, only the valid is steered
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        ex_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (lane_in_valid[i]),
            .in_ready  (lane_in_ready[i]),
            .op        (op),
            .rs1_data  (rs1_data),
            .rs2_data  (rs2_data),
            .pc        (pc),
            .imm       (imm),
            .sel_pc    (sel_pc),
            .sel_imm   (sel_imm),
            .out_valid (lane_out_valid[i]),
            .out_ready (lane_out_ready[i]),
            .result    (lane_result[i]),
            .target    (lane_target[i]),
            .taken     (lane_taken[i])
        );
    end

    ex_retire #(.LANES(LANES)) u_retire (
        .clk            (clk),
        .rst_n          (rst_n),
        .lane_out_valid (lane_out_valid),
        .lane_result    (lane_result),
        .lane_target    (lane_target),
        .lane_taken     (lane_taken),
        .lane_out_ready (lane_out_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .result         (result),
        .target         (branch_target),
        .taken          (branch_taken)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ex_top -f verilog.f \
    && ./obj_dir/Vtb_ex_top > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// ==== tb_ex_checker.sv ====
// Scoreboard for the execute stage
// Models every accepted instruction and compares the results in retire order
`timescale 1ns/10ps
`default_nettype none

module tb_ex_checker (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           in_valid,
    input  wire logic                           in_ready,
    input  wire ex_pkg::alu_op_e                op,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  rs1_data,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  rs2_data,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  pc,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  imm,
    input  wire logic                           sel_pc,
    input  wire logic                           sel_imm,
    input  wire logic                           out_valid,
    input  wire logic                           out_ready,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  result,
    input  wire logic                           branch_taken,
    input  wire logic [ex_pkg::DATA_WIDTH-1:0]  branch_target,
    output int                                  accepted,
    output int                                  checked,
    output int                                  errors,
    output int                                  pending
);
    localparam int W = ex_pkg::DATA_WIDTH;

    logic [2*W+5:0] exp_q[$];  // Entry is {op, taken, target, result}
    logic           stalled;
    logic [2*W:0]   held;

    // RV32M rules with the divide-by-zero and overflow results
    function automatic logic [W-1:0] mdu_model(ex_pkg::alu_op_e f, logic [W-1:0] a,
                                               logic [W-1:0] b);
        logic [2*W-1:0]      sa;
        logic [2*W-1:0]      sb;
        logic [2*W-1:0]      ua;
        logic [2*W-1:0]      ub;
        logic                ovf;
        logic signed [W-1:0] q;
        logic signed [W-1:0] r;
        sa  = {{W{a[W-1]}}, a};
        sb  = {{W{b[W-1]}}, b};
        ua  = {{W{1'b0}}, a};
        ub  = {{W{1'b0}}, b};
        ovf = (a == {1'b1, {(W-1){1'b0}}}) && (b == '1);
        q   = '0;
        r   = '0;
        if (b != '0 && !ovf) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
        case (f)
            ex_pkg::OP_MUL:    return W'(ua * ub);
            ex_pkg::OP_MULH:   return W'((sa * sb) >> W);
            ex_pkg::OP_MULHSU: return W'((sa * ub) >> W);
            ex_pkg::OP_MULHU:  return W'((ua * ub) >> W);
            ex_pkg::OP_DIV:    return (b == '0) ? '1 : (ovf ? a : q);
            ex_pkg::OP_DIVU:   return (b == '0) ? '1 : a / b;
            ex_pkg::OP_REM:    return (b == '0) ? a : (ovf ? '0 : r);
            ex_pkg::OP_REMU:   return (b == '0) ? a : a % b;
            default:           return '0;
        endcase
    endfunction

    function automatic logic [W-1:0] alu_model(ex_pkg::alu_op_e f, logic [W-1:0] a,
                                               logic [W-1:0] b, logic [W-1:0] p);
        case (f)
            ex_pkg::OP_ADD:  return a + b;
            ex_pkg::OP_SUB:  return a - b;
            ex_pkg::OP_SLL:  return a << b[4:0];
            ex_pkg::OP_SLT:  return {{(W-1){1'b0}}, $signed(a) < $signed(b)};
            ex_pkg::OP_SLTU: return {{(W-1){1'b0}}, a < b};
            ex_pkg::OP_XOR:  return a ^ b;
            ex_pkg::OP_SRL:  return a >> b[4:0];
            ex_pkg::OP_SRA:  return $signed(a) >>> b[4:0];
            ex_pkg::OP_OR:   return a | b;
            ex_pkg::OP_AND:  return a & b;
            ex_pkg::OP_LUI:  return b;
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: return p + 4;  // Link address
            ex_pkg::OP_MUL, ex_pkg::OP_MULH, ex_pkg::OP_MULHSU, ex_pkg::OP_MULHU,
            ex_pkg::OP_DIV, ex_pkg::OP_DIVU, ex_pkg::OP_REM, ex_pkg::OP_REMU:
                return mdu_model(f, a, b);
            default:         return '0;
        endcase
    endfunction

    function automatic logic taken_model(ex_pkg::alu_op_e f, logic [W-1:0] x, logic [W-1:0] y);
        case (f)
            ex_pkg::OP_BEQ:  return x == y;
            ex_pkg::OP_BNE:  return x != y;
            ex_pkg::OP_BLT:  return $signed(x) < $signed(y);
            ex_pkg::OP_BGE:  return $signed(x) >= $signed(y);
            ex_pkg::OP_BLTU: return x < y;
            ex_pkg::OP_BGEU: return x >= y;
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic logic [W-1:0] target_model(ex_pkg::alu_op_e f, logic [W-1:0] x,
                                                  logic [W-1:0] p, logic [W-1:0] i);
        case (f)
            ex_pkg::OP_BEQ, ex_pkg::OP_BNE, ex_pkg::OP_BLT, ex_pkg::OP_BGE,
            ex_pkg::OP_BLTU, ex_pkg::OP_BGEU, ex_pkg::OP_JAL: return p + i;
            ex_pkg::OP_JALR: return (x + i) & {{(W-1){1'b1}}, 1'b0};
            default:         return '0;
        endcase
    endfunction

    task automatic compare_field(string sig, string ctx, logic [W-1:0] expected,
                                 logic [W-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h (%s, at %0t)",
                     sig, expected, actual, ctx, $time);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        logic [W-1:0]    a;
        logic [W-1:0]    b;
        logic [2*W+5:0]  head;
        ex_pkg::alu_op_e head_op;
        if (!rst_n) begin
            exp_q.delete();
            accepted = 0;
            checked  = 0;
            errors   = 0;
            stalled  = 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                a = sel_pc ? pc : rs1_data;
                b = sel_imm ? imm : rs2_data;
                exp_q.push_back({op, taken_model(op, rs1_data, rs2_data),
                                 target_model(op, rs1_data, pc, imm), alu_model(op, a, b, pc)});
                accepted++;
            end
            // A stalled output must hold all of its fields
            if (stalled && !out_valid) begin
                $display("out_valid dropped before the result was taken at %0t", $time);
                errors++;
            end else if (stalled) begin
                compare_field("result", "held", held[W-1:0], result);
                compare_field("branch_target", "held", held[2*W-1:W], branch_target);
                compare_field("branch_taken", "held", W'(held[2*W]), W'(branch_taken));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out with no instruction outstanding at %0t", $time);
                    errors++;
                end else begin
                    head    = exp_q.pop_front();
                    head_op = ex_pkg::alu_op_e'(head[2*W+5:2*W+1]);
                    compare_field("result", head_op.name(),
                                  head[W-1:0], result);
                    compare_field("branch_target", head_op.name(),
                                  head[2*W-1:W], branch_target);
                    compare_field("branch_taken", head_op.name(),
                                  W'(head[2*W]), W'(branch_taken));
                    checked++;
                end
            end
            stalled = out_valid && !out_ready;
            held    = {branch_taken, branch_target, result};
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== tb_ex_top.sv ====
// Testbench for the multi-lane execute stage
// Random instruction stream from an LFSR, with input gaps and output stalls
`timescale 1ns/10ps
`default_nettype none

module tb_ex_top;
    localparam int W              = ex_pkg::DATA_WIDTH;
    localparam int N_INSTR        = 400;
    localparam int TIMEOUT_CYCLES = N_INSTR * 40 + 100;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    ex_pkg::alu_op_e op;
    logic [W-1:0]    rs1_data;
    logic [W-1:0]    rs2_data;
    logic [W-1:0]    pc;
    logic [W-1:0]    imm;
    logic            sel_pc;
    logic            sel_imm;
    logic            out_valid;
    logic            out_ready;
    logic [W-1:0]    result;
    logic            branch_taken;
    logic [W-1:0]    branch_target;
    int              accepted;
    int              checked;
    int              errors;
    int              pending;
    int              cycles = 0;
    logic [31:0]     lfsr   = 32'd71341;

    ex_top #(.LANES(2)) u_ex_top (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready), .op(op),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc), .imm(imm),
        .sel_pc(sel_pc), .sel_imm(sel_imm), .out_valid(out_valid), .out_ready(out_ready),
        .result(result), .branch_taken(branch_taken), .branch_target(branch_target)
    );

    tb_ex_checker u_checker (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready), .op(op),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc), .imm(imm),
        .sel_pc(sel_pc), .sel_imm(sel_imm), .out_valid(out_valid), .out_ready(out_ready),
        .result(result), .branch_taken(branch_taken), .branch_target(branch_target),
        .accepted(accepted), .checked(checked), .errors(errors), .pending(pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Roughly one in eight operands lands on a corner value
    function automatic logic [W-1:0] pick_operand();
        if (take_bits(3) != 0) return take_bits(32);
        case (take_bits(2))
            0:       return '0;
            2:       return {1'b1, {(W-1){1'b0}}};
            default: return '1;
        endcase
    endfunction

    function automatic ex_pkg::alu_op_e pick_opcode();
        logic [31:0] r;
        if (take_bits(3) == 0) begin
            r = take_bits(2) + 32'(ex_pkg::OP_DIV);  // Divides sit at the end of the enum
            return ex_pkg::alu_op_e'(r[4:0]);
        end
        r = take_bits(5) % 23;
        return ex_pkg::alu_op_e'(r[4:0]);
    endfunction

    task automatic new_payload();
        op       = pick_opcode();
        rs1_data = pick_operand();
        rs2_data = pick_operand();
        imm      = pick_operand();
        pc       = take_bits(30) << 2;
        sel_pc   = take_bits(1) != 0;
        sel_imm  = take_bits(1) != 0;
        // Push a share of the divides into the overflow and divide-by-zero corners
        if (op inside {ex_pkg::OP_DIV, ex_pkg::OP_DIVU, ex_pkg::OP_REM, ex_pkg::OP_REMU}) begin
            case (take_bits(2))
                0: begin
                    rs1_data = {1'b1, {(W-1){1'b0}}};
                    rs2_data = '1;
                    imm      = '1;
                    sel_pc   = 1'b0;
                end
                1: begin
                    rs2_data = '0;
                    imm      = '0;
                end
                default: ;
            endcase
        end
    endtask

    task automatic finish_run(logic timed_out);
        int total;
        total = errors + (timed_out ? 1 : 0);
        if (pending != 0) begin
            $display("%0d accepted instructions were never retired", pending);
            total++;
        end
        $display("Accepted %0d, checked %0d, errors %0d", accepted, checked, total);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        int   sent;
        logic fired;
        sent      = 0;
        fired     = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        op        = ex_pkg::OP_ADD;
        rs1_data  = '0;
        rs2_data  = '0;
        pc        = '0;
        imm       = '0;
        sel_pc    = 1'b0;
        sel_imm   = 1'b0;
        out_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (checked < N_INSTR) begin
            @(negedge clk);
            if (fired) sent++;
            out_ready = take_bits(4) < 11;  // About 70 percent
            if (sent >= N_INSTR) begin
                in_valid = 1'b0;
            end else if (!in_valid || fired) begin
                in_valid = take_bits(2) != 0;
                if (in_valid) new_payload();
            end
            fired = in_valid && in_ready;  // in_ready only moves on the rising edge
        end
        out_ready = 1'b1;
        repeat (10) @(negedge clk);  // Catch any extra result after the last one
        finish_run(1'b0);
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) @(negedge clk);
        $display("Timeout: not all results were received");
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
ex_pkg.sv
ex_alu.sv
ex_muldiv.sv
ex_lane.sv
ex_issue.sv
ex_retire.sv
ex_top.sv
tb_ex_checker.sv
tb_ex_top.sv
